/* Bender.yml */
package:
  name: ldpc_sched

sources:
  - include_dirs:
      - source
    files:
      - source/ldpc_sched_pkg.sv
      - source/stage_timer.sv
      - source/layer_tracker.sv
      - source/ib_load_ctrl.sv
      - source/strobe_decode.sv
      - source/sched_fsm.sv
      - source/ldpc_sched_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/tb_ldpc_sched.sv

/* source/ib_load_ctrl.sv */
`timescale 1ns/1ps
`include "ldpc_sched_defs.svh"

// load sequencer for one IB-RAM
// init and pipe loads run the same wr / ack sequence
module ib_load_ctrl (
	input  logic read_clk,
	input  logic rstn,
	input  logic init_start_i,   // from INIT_LOAD
	input  logic pipe_start_i,   // from the last layer finish
	input  logic iter_update_i,  // ack level from the IB memory
	output logic wr_o,           // table write request
	output logic pending_o       // load still open, holds the scheduler in IB_PEND
);
	localparam int MIN_CYC = `LDPC_LOAD_MIN_CYC;
	localparam int MIN_W   = $clog2(MIN_CYC + 1);

	logic             load_q;     // a load is in flight
	logic [MIN_W-1:0] min_cnt_q;  // wr cycles already spent, saturating
	logic             start;
	logic             min_met;    // this wr cycle is at least the MIN_CYC-th
	logic             ack_ok;

	assign start   = init_start_i | pipe_start_i;
	assign min_met = (min_cnt_q >= MIN_W'(MIN_CYC - 1));
	// an early ack is ignored, the memory keeps it high until taken
	assign ack_ok  = load_q && min_met && iter_update_i;

	////////////////////
	// load flag
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			load_q <= 1'b0;
		end else if (start) begin
			load_q <= 1'b1;  // a new start restarts a running load
		end else if (ack_ok) begin
			load_q <= 1'b0;
		end
	end

	////////////////////
	// minimum wr length
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			min_cnt_q <= '0;
		end else if (start) begin
			min_cnt_q <= '0;
		end else if (load_q && !min_met) begin
			min_cnt_q <= min_cnt_q + 1'b1;
		end
	end

	// wr and pending open together the cycle after start
	// and close together the cycle after the accepted ack
	assign wr_o      = load_q;
	assign pending_o = load_q;

	// a write never ends short of MIN_CYC cycles or without an ack
	a_wr_close: assert property (@(posedge read_clk) disable iff (!rstn)
		$fell(wr_o) |-> $fell(pending_o) && $past(wr_o, MIN_CYC) && $past(iter_update_i));

	// wr is never high while nothing is pending
	a_wr_pending: assert property (@(posedge read_clk) disable iff (!rstn)
		wr_o |-> pending_o);

endmodule

/* source/layer_tracker.sv */
`timescale 1ns/1ps
`include "ldpc_sched_defs.svh"

// layer and iteration position, plus the layer sweep that times layer_finish
module layer_tracker (
	input  logic                            read_clk,
	input  logic                            rstn,
	input  ldpc_sched_pkg::sched_state_e    state_i,
	output ldpc_sched_pkg::layer_pos_t      pos_o
);
	import ldpc_sched_pkg::*;

	localparam int LAYERS  = `LDPC_LAYER_NUM;
	localparam int ITERS   = `LDPC_MAX_ITER;
	localparam int SWEEP   = `LDPC_LAYER_SWEEP_CYC;
	localparam int SWEEP_W = $clog2(SWEEP + 1);

	logic [LAYERS-1:0]  layer_q;
	logic [ITERS-1:0]   iter_q;
	logic [SWEEP_W-1:0] sweep_q;    // cycles since MEM_FETCH was entered
	logic               in_sweep;
	logic               layer_finish;
	logic               last_layer;

	assign in_sweep     = (state_i >= MEM_FETCH);  // MEM_FETCH through IDLE
	assign layer_finish = in_sweep && (sweep_q == SWEEP_W'(SWEEP));
	assign last_layer   = layer_q[LAYERS-1];

	////////////////////
	// sweep counter, cleared outside the sweep and after the finish pulse
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) sweep_q <= '0;
		else if (in_sweep && !layer_finish) sweep_q <= sweep_q + 1'b1;
		else sweep_q <= '0;
	end

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			layer_q <= LAYERS'(1);  // first layer
			iter_q  <= ITERS'(1);   // first iteration
		end else if (layer_finish) begin
			layer_q <= {layer_q[LAYERS-2:0], layer_q[LAYERS-1]};  // rotate
			if (last_layer) iter_q <= {iter_q[ITERS-2:0], 1'b0};  // zero fill
		end
	end

	always_comb begin
		pos_o.layer        = layer_q;
		pos_o.iter         = iter_q;
		pos_o.last_layer   = last_layer;
		pos_o.layer_finish = layer_finish;
	end

	a_layer_onehot: assert property (@(posedge read_clk) disable iff (!rstn) $onehot(layer_q));

endmodule

/* source/ldpc_sched_defs.svh */
`ifndef LDPC_SCHED_DEFS_SVH
`define LDPC_SCHED_DEFS_SVH

////////////////////
// code geometry

`define LDPC_LAYER_NUM       3  // layers per iteration
`define LDPC_MAX_ITER        8  // width of the iteration one-hot
`define LDPC_VNU_FUNC_NUM    2  // VNU decomposition groups, one IB-RAM each

////////////////////
// stage lengths in read_clk cycles

`define LDPC_VNU_FUNC_CYC    3  // latency of one VNU group
`define LDPC_CH_BUBBLE_CYC   2  // bubble between channel fetch and memory fetch
`define LDPC_MEM_RD_CYC      2  // message memory read
`define LDPC_PERM_CYC        2  // barrel shifter depth
`define LDPC_LAYER_SWEEP_CYC 18 // MEM_FETCH entry to layer_finish

////////////////////
// handshake and counter widths

`define LDPC_LOAD_MIN_CYC    3  // wr cycles before an ack is taken
`define LDPC_STAGE_CNT_W     3  // holds the longest fixed stage, VNU pipe plus out

`endif

/* source/ldpc_sched_pkg.sv */
`include "ldpc_sched_defs.svh"

package ldpc_sched_pkg;

	////////////////////
	// scheduler states, in pipeline order
	// the order matters: MEM_FETCH and beyond count as the layer sweep
	typedef enum logic [3:0] {
		INIT_LOAD,  // kick off the initial IB-RAM loads
		IB_PEND,    // wait for every IB-RAM load to finish
		CH_FETCH,   // channel RAM read
		CH_BUBBLE,
		MEM_FETCH,  // c2v message memory read
		VNU_PIPE,
		VNU_OUT,    // last VNU register, shared with the shifter input
		BS_WB,      // barrel shift
		PAGE_ALIGN,
		MEM_WB,     // v2c message write-back
		IDLE        // drain until the layer sweep ends
	} sched_state_e;

	////////////////////
	// datapath strobes
	typedef struct packed {
		logic src;        // take channel values instead of v2c on the very first layer
		logic mem_fetch;  // c2v memory read enable
		logic bs_en;
		logic pa_en;
		logic mem_we;     // v2c memory write enable
	} v2c_strobe_t;

	typedef struct packed {
		logic ram_fetch;  // channel buffer read
		logic bs_en;
		logic pa_en;
		logic ram_wb;
	} ch_strobe_t;

	// where the decoder stands in the layer / iteration sweep
	typedef struct packed {
		logic [`LDPC_LAYER_NUM-1:0] layer;  // one-hot, bit 0 is the first layer
		logic [`LDPC_MAX_ITER-1:0]  iter;   // one-hot, shifts out after the last iteration
		logic                       last_layer;
		logic                       layer_finish;  // single-cycle pulse
	} layer_pos_t;

endpackage

/* source/ldpc_sched_top.sv */
`timescale 1ns/1ps
`include "ldpc_sched_defs.svh"

// layer scheduler top
module ldpc_sched_top (
	input  logic                            read_clk,
	input  logic                            rstn,
	input  logic                            fsm_en_i,
	input  logic                            termination_i,
	input  logic [`LDPC_VNU_FUNC_NUM-1:0]   vn_iter_update_i,
	input  logic                            dn_iter_update_i,
	output logic [`LDPC_VNU_FUNC_NUM-1:0]   vnu_wr_o,
	output logic                            dnu_wr_o,
	output logic [`LDPC_VNU_FUNC_NUM-1:0]   vnu_rd_o,
	output logic                            dnu_rd_o,
	output ldpc_sched_pkg::v2c_strobe_t     v2c_o,
	output ldpc_sched_pkg::ch_strobe_t      ch_o,
	output ldpc_sched_pkg::layer_pos_t      pos_o,
	output logic                            decode_busy_o
);
	import ldpc_sched_pkg::*;

	localparam int IB_NUM = `LDPC_VNU_FUNC_NUM + 1;  // top bit is the DNU

	sched_state_e                 state;
	logic                         stage_last;
	logic [`LDPC_STAGE_CNT_W-1:0] stage_cyc;
	logic                         init_start;
	logic                         pipe_start;
	logic [IB_NUM-1:0]            ib_ack;
	logic [IB_NUM-1:0]            ib_wr;
	logic [IB_NUM-1:0]            ib_pending;

	assign ib_ack   = {dn_iter_update_i, vn_iter_update_i};
	assign vnu_wr_o = ib_wr[IB_NUM-2:0];
	assign dnu_wr_o = ib_wr[IB_NUM-1];

	sched_fsm u_fsm (
		.read_clk(read_clk), .rstn(rstn),
		.fsm_en_i(fsm_en_i), .termination_i(termination_i),
		.stage_last_i(stage_last),
		.layer_finish_i(pos_o.layer_finish), .last_layer_i(pos_o.last_layer),
		.load_pending_i(ib_pending),
		.state_o(state), .init_start_o(init_start), .pipe_start_o(pipe_start),
		.decode_busy_o(decode_busy_o)
	);

	stage_timer u_timer (.read_clk(read_clk), .rstn(rstn), .state_i(state),
		.stage_last_o(stage_last), .stage_cyc_o(stage_cyc));

	layer_tracker u_layer (.read_clk(read_clk), .rstn(rstn), .state_i(state), .pos_o(pos_o));

	// one load sequencer per VNU group, the last one for the DNU
	for (genvar i = 0; i < IB_NUM; i++) begin : g_ib
		ib_load_ctrl u_ib (
			.read_clk(read_clk), .rstn(rstn),
			.init_start_i(init_start), .pipe_start_i(pipe_start),
			.iter_update_i(ib_ack[i]),
			.wr_o(ib_wr[i]), .pending_o(ib_pending[i])
		);
	end

	strobe_decode u_strobe (
		.state_i(state), .stage_cyc_i(stage_cyc), .pos_i(pos_o),
		.read_clk(read_clk), .rstn(rstn),
		.vnu_rd_o(vnu_rd_o), .dnu_rd_o(dnu_rd_o), .v2c_o(v2c_o), .ch_o(ch_o)
	);

endmodule

/* source/sched_fsm.sv */
`timescale 1ns/1ps
`include "ldpc_sched_defs.svh"

// main layer sequencer
// fixed-length stages advance on stage_last while IB_PEND and IDLE wait on events
module sched_fsm (
	input  logic                            read_clk,
	input  logic                            rstn,
	input  logic                            fsm_en_i,       // low level parks at INIT_LOAD
	input  logic                            termination_i,  // restart after a finished frame
	input  logic                            stage_last_i,
	input  logic                            layer_finish_i,
	input  logic                            last_layer_i,
	input  logic [`LDPC_VNU_FUNC_NUM:0]     load_pending_i, // VNU groups plus the DNU
	output ldpc_sched_pkg::sched_state_e    state_o,
	output logic                            init_start_o,
	output logic                            pipe_start_o,
	output logic                            decode_busy_o
);
	import ldpc_sched_pkg::*;

	sched_state_e state_q;
	sched_state_e state_nxt;
	logic         load_busy;  // any IB-RAM still loading

	assign load_busy = |load_pending_i;

	////////////////////
	// next state
	always_comb begin
		state_nxt = state_q;
		case (state_q)
			INIT_LOAD: state_nxt = IB_PEND;  // loads start here and pending shows next cycle
			IB_PEND: begin
				if (!load_busy) state_nxt = CH_FETCH;
			end
			CH_FETCH: begin
				if (stage_last_i) state_nxt = CH_BUBBLE;
			end
			CH_BUBBLE: begin
				if (stage_last_i) state_nxt = MEM_FETCH;
			end
			MEM_FETCH: begin
				if (stage_last_i) state_nxt = VNU_PIPE;
			end
			VNU_PIPE: begin
				if (stage_last_i) state_nxt = VNU_OUT;
			end
			VNU_OUT: begin
				if (stage_last_i) state_nxt = BS_WB;
			end
			BS_WB: begin
				if (stage_last_i) state_nxt = PAGE_ALIGN;
			end
			PAGE_ALIGN: begin
				if (stage_last_i) state_nxt = MEM_WB;
			end
			MEM_WB: begin
				if (stage_last_i) state_nxt = IDLE;
			end
			IDLE: begin
				// a pipe load issued this cycle is not yet visible in load_pending_i
				if (layer_finish_i) begin
					state_nxt = (load_busy || pipe_start_o) ? IB_PEND : CH_FETCH;
				end
			end
			default: state_nxt = INIT_LOAD;  // illegal encoding starts over
		endcase
	end

	////////////////////
	// state register
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			state_q <= INIT_LOAD;
		end else if (!fsm_en_i || termination_i) begin
			state_q <= INIT_LOAD;  // held or restarted
		end else begin
			state_q <= state_nxt;
		end
	end

	// init loads only once the decoder is really leaving INIT_LOAD
	assign init_start_o  = (state_q == INIT_LOAD) && fsm_en_i && !termination_i;
	// IB tables for the next iteration once the last layer has drained
	assign pipe_start_o  = (state_q == IDLE) && layer_finish_i && last_layer_i;
	assign decode_busy_o = (state_q == IB_PEND);
	assign state_o       = state_q;

	// state register never holds one of the five unused codes
	a_state_legal: assert property (@(posedge read_clk) disable iff (!rstn)
		!$isunknown(state_q) && (state_q <= IDLE));

	// the layer sweep ends only in IDLE and pipe loads need that end
	a_pipe_start_idle: assert property (@(posedge read_clk) disable iff (!rstn)
		layer_finish_i |-> (state_q == IDLE));

endmodule

/* source/stage_timer.sv */
`timescale 1ns/1ps
`include "ldpc_sched_defs.svh"

// cycle count inside the current stage plus the last-cycle flag
module stage_timer (
	input  logic                            read_clk,
	input  logic                            rstn,
	input  ldpc_sched_pkg::sched_state_e    state_i,
	output logic                            stage_last_o,
	output logic [`LDPC_STAGE_CNT_W-1:0]    stage_cyc_o   // 0 on the entry cycle
);
	import ldpc_sched_pkg::*;

	localparam int CNT_W   = `LDPC_STAGE_CNT_W;
	localparam int VNU_CYC = `LDPC_VNU_FUNC_NUM * `LDPC_VNU_FUNC_CYC;  // pipe + out
	localparam logic [CNT_W-1:0] CNT_MAX = '1;

	sched_state_e     prev_q;     // state seen last cycle
	logic [CNT_W-1:0] cyc_q;
	logic             entry;      // first cycle of a new stage
	int unsigned      stage_len;  // 0 for event-driven stages

	// VNU_OUT keeps counting on from VNU_PIPE so the group slices line up
	function automatic sched_state_e stage_group(sched_state_e s);
		return (s == VNU_OUT) ? VNU_PIPE : s;
	endfunction

	// length table, VNU_OUT given as the end of the joint VNU count
	function automatic int unsigned stage_len_of(sched_state_e s);
		case (s)
			INIT_LOAD:  return 1;
			CH_FETCH:   return 1;
			CH_BUBBLE:  return `LDPC_CH_BUBBLE_CYC;
			MEM_FETCH:  return `LDPC_MEM_RD_CYC;
			VNU_PIPE:   return VNU_CYC - 1;  // the last slot belongs to VNU_OUT
			VNU_OUT:    return VNU_CYC;
			BS_WB:      return `LDPC_PERM_CYC;
			PAGE_ALIGN: return 1;
			MEM_WB:     return 1;
			default:    return 0;  // IB_PEND and IDLE
		endcase
	endfunction

	assign entry        = (stage_group(state_i) != stage_group(prev_q));
	assign stage_cyc_o  = entry ? '0 : cyc_q;
	assign stage_len    = stage_len_of(state_i);
	assign stage_last_o = (stage_len != 0) && (stage_cyc_o == CNT_W'(stage_len - 1));

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			prev_q <= INIT_LOAD;
			cyc_q  <= '0;
		end else begin
			prev_q <= state_i;
			cyc_q  <= (stage_cyc_o == CNT_MAX) ? CNT_MAX : stage_cyc_o + 1'b1;  // saturate in the waits
		end
	end

endmodule

/* source/strobe_decode.sv */
`timescale 1ns/1ps
`include "ldpc_sched_defs.svh"

// datapath strobes from state, stage cycle and layer position
module strobe_decode (
	input  ldpc_sched_pkg::sched_state_e    state_i,
	input  logic [`LDPC_STAGE_CNT_W-1:0]    stage_cyc_i,
	input  ldpc_sched_pkg::layer_pos_t      pos_i,
	input  logic                            read_clk,
	input  logic                            rstn,
	output logic [`LDPC_VNU_FUNC_NUM-1:0]   vnu_rd_o,
	output logic                            dnu_rd_o,
	output ldpc_sched_pkg::v2c_strobe_t     v2c_o,
	output ldpc_sched_pkg::ch_strobe_t      ch_o
);
	import ldpc_sched_pkg::*;

	localparam int FUNC_CYC = `LDPC_VNU_FUNC_CYC;
	localparam int CNT_W    = `LDPC_STAGE_CNT_W;

	logic in_vnu;
	logic first_layer;  // first layer of any iteration
	logic first_pass;   // first layer of the first iteration
	logic fetch_first;  // entry cycle of MEM_FETCH
	logic ch_pa_en;
	logic ch_ram_wb_q;

	assign in_vnu      = (state_i == VNU_PIPE) || (state_i == VNU_OUT);
	assign first_layer = pos_i.layer[0];
	assign first_pass  = pos_i.layer[0] && pos_i.iter[0];
	assign fetch_first = (state_i == MEM_FETCH) && (stage_cyc_i == '0);
	assign ch_pa_en    = fetch_first && first_layer;

	// VNU group j reads its IB-RAM during its own slice of the VNU count
	for (genvar j = 0; j < `LDPC_VNU_FUNC_NUM; j++) begin : g_vnu_rd
		assign vnu_rd_o[j] = in_vnu && (int'(stage_cyc_i) >= j * FUNC_CYC)
			&& (int'(stage_cyc_i) < (j + 1) * FUNC_CYC);
	end

	assign dnu_rd_o = (state_i == BS_WB) || (state_i == PAGE_ALIGN);  // DNU sits beside the shifter

	always_comb begin
		v2c_o.src       = (state_i == MEM_FETCH) && first_pass
			&& (stage_cyc_i == CNT_W'(`LDPC_MEM_RD_CYC - 1));
		v2c_o.mem_fetch = fetch_first;
		v2c_o.bs_en     = (state_i == BS_WB) && (stage_cyc_i == '0);  // first shifter cycle only
		v2c_o.pa_en     = (state_i == PAGE_ALIGN);
		v2c_o.mem_we    = (state_i == MEM_WB);
		ch_o.ram_fetch  = (state_i == CH_FETCH);
		ch_o.bs_en      = (state_i == CH_BUBBLE) && (stage_cyc_i == '0) && first_pass;
		ch_o.pa_en      = ch_pa_en;
		ch_o.ram_wb     = ch_ram_wb_q;
	end

	// channel write-back trails the page alignment by one cycle
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) ch_ram_wb_q <= 1'b0;
		else ch_ram_wb_q <= ch_pa_en && first_pass;
	end

endmodule

/* sources.f */
+incdir+source
source/ldpc_sched_pkg.sv
source/stage_timer.sv
source/layer_tracker.sv
source/ib_load_ctrl.sv
source/strobe_decode.sv
source/sched_fsm.sv
source/ldpc_sched_top.sv
tb/tb_ldpc_sched.sv

/* tb/tb_ldpc_sched.sv */
`timescale 1ns/1ps
`include "ldpc_sched_defs.svh"

module tb_ldpc_sched;
	import ldpc_sched_pkg::*;

	localparam int VNU_NUM  = `LDPC_VNU_FUNC_NUM;
	localparam int IB_NUM   = VNU_NUM + 1;
	localparam int LAYERS   = `LDPC_LAYER_NUM;
	localparam int ITERS    = `LDPC_MAX_ITER;
	localparam int FUNC_CYC = `LDPC_VNU_FUNC_CYC;
	// strobe offsets counted from ch ram_fetch
	localparam int OFF_MEMF = 1 + `LDPC_CH_BUBBLE_CYC;
	localparam int OFF_VNU  = OFF_MEMF + `LDPC_MEM_RD_CYC;
	localparam int OFF_BS   = OFF_VNU + VNU_NUM * FUNC_CYC;
	localparam int OFF_PA   = OFF_BS + `LDPC_PERM_CYC;
	localparam int OFF_WB   = OFF_PA + 1;
	localparam int OFF_FIN  = OFF_MEMF + `LDPC_LAYER_SWEEP_CYC;
	localparam int TERM_OFS = 8;    // lands inside the VNU pipe
	localparam int ROWS     = 4;
	localparam int CYC_PER_LAYER = 40;

	typedef struct {
		int layers;
		int ack_dly;     // base ack delay in wr cycles
		int term_layer;  // layer of the row cut short by termination or -1
		int exp_finish;  // layer_finish pulses expected in the row
	} test_row_t;

	test_row_t rows [ROWS] = '{
		'{4, 1, -1, 4},  // crosses an iteration with pipe loads
		'{3, 5, 1, 2},
		'{5, 0, -1, 5},  // early acks so the minimum wr length decides
		'{2, 3, 0, 1}
	};

	logic              read_clk = 1'b0;
	logic              rstn;
	logic              fsm_en_i;
	logic              termination_i;
	logic [IB_NUM-1:0] ack_drv = '0;  // top bit acks the DNU
	logic [VNU_NUM-1:0] vnu_wr_o;
	logic              dnu_wr_o;
	logic [VNU_NUM-1:0] vnu_rd_o;
	logic              dnu_rd_o;
	v2c_strobe_t       v2c_o;
	ch_strobe_t        ch_o;
	layer_pos_t        pos_o;
	logic              decode_busy_o;

	// checker state
	int                cyc = 0;
	int                fetch_cyc = 0;
	int                fetch_due = -1;  // cycle of the next ram_fetch
	int                load_due = -1;   // cycle in which every wr rises
	int                checks = 0;
	int                errors = 0;
	int                finishes = 0;
	int                cur_ack = 0;
	int                wr_len [IB_NUM] = '{default: 0};
	int                ack_delay [IB_NUM] = '{default: 0};
	logic              layer_open = 1'b0;
	logic              first_pass = 1'b0;   // first layer of first iteration
	logic              first_layer = 1'b0;
	logic              en_seen = 1'b0;
	logic [IB_NUM-1:0] wr_seen = '0;
	logic [IB_NUM-1:0] ack_seen = '0;
	logic [LAYERS-1:0] exp_layer = LAYERS'(1);
	logic [ITERS-1:0]  exp_iter = ITERS'(1);
	logic [31:0]       seed = 32'hceadefd4;

	always #5 read_clk = ~read_clk;  // 10 ns

	ldpc_sched_top dut_i (
		.read_clk(read_clk), .rstn(rstn),
		.fsm_en_i(fsm_en_i), .termination_i(termination_i),
		.vn_iter_update_i(ack_drv[VNU_NUM-1:0]), .dn_iter_update_i(ack_drv[IB_NUM-1]),
		.vnu_wr_o(vnu_wr_o), .dnu_wr_o(dnu_wr_o), .vnu_rd_o(vnu_rd_o), .dnu_rd_o(dnu_rd_o),
		.v2c_o(v2c_o), .ch_o(ch_o), .pos_o(pos_o), .decode_busy_o(decode_busy_o)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic check_eq(input string what, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic wait_fetch();
		do begin
			@(negedge read_clk);
		end while (!ch_o.ram_fetch);
	endtask

	task automatic wait_finish();
		do begin
			@(negedge read_clk);
		end while (!pos_o.layer_finish);
	endtask

	task automatic wait_load();
		do begin
			@(negedge read_clk);
		end while (!(|{dnu_wr_o, vnu_wr_o}));
	endtask

	////////////////////
	// ack model where the memory holds the ack until wr drops
	always @(posedge read_clk) begin
		for (int i = 0; i < IB_NUM; i++) begin
			if (!wr_seen[i]) ack_drv[i] <= 1'b0;
			else if (wr_len[i] >= ack_delay[i]) ack_drv[i] <= 1'b1;
		end
	end

	////////////////////
	// strobe and position monitor
	always @(negedge read_clk) begin : monitor
		logic [IB_NUM-1:0]  wr_now;
		logic [VNU_NUM-1:0] exp_vnu;
		v2c_strobe_t        exp_v2c;
		ch_strobe_t         exp_ch;
		int                 f;
		if (rstn) begin
			cyc++;
			wr_now = {dnu_wr_o, vnu_wr_o};
			if (ch_o.ram_fetch) begin  // a layer starts with the position from the model
				layer_open  = 1'b1;
				fetch_cyc   = cyc;
				first_pass  = exp_layer[0] && exp_iter[0];
				first_layer = exp_layer[0];
			end
			f = cyc - fetch_cyc;
			exp_ch.ram_fetch  = (cyc == fetch_due);
			exp_ch.bs_en      = layer_open && first_pass && (f == 1);
			exp_ch.pa_en      = layer_open && first_layer && (f == OFF_MEMF);
			exp_ch.ram_wb     = layer_open && first_pass && (f == OFF_MEMF + 1);
			exp_v2c.src       = layer_open && first_pass && (f == OFF_VNU - 1);
			exp_v2c.mem_fetch = layer_open && (f == OFF_MEMF);
			exp_v2c.bs_en     = layer_open && (f == OFF_BS);
			exp_v2c.pa_en     = layer_open && (f == OFF_PA);
			exp_v2c.mem_we    = layer_open && (f == OFF_WB);
			for (int j = 0; j < VNU_NUM; j++)
				exp_vnu[j] = layer_open && (f >= OFF_VNU + j * FUNC_CYC)
					&& (f < OFF_VNU + (j + 1) * FUNC_CYC);
			check_eq("ch strobes", 16'(ch_o), 16'(exp_ch));
			check_eq("v2c strobes", 16'(v2c_o), 16'(exp_v2c));
			check_eq("vnu_rd", 16'(vnu_rd_o), 16'(exp_vnu));
			check_eq("dnu_rd", 16'(dnu_rd_o), 16'(layer_open && f >= OFF_BS && f <= OFF_PA));
			check_eq("layer_finish", 16'(pos_o.layer_finish), 16'(layer_open && f == OFF_FIN));
			check_eq("layer one-hot", 16'(pos_o.layer), 16'(exp_layer));
			check_eq("iteration one-hot", 16'(pos_o.iter), 16'(exp_iter));
			check_eq("last_layer", 16'(pos_o.last_layer), 16'(exp_layer[LAYERS-1]));
			check_eq("decode_busy", 16'(decode_busy_o), 16'((|wr_now) || (|wr_seen)));
			check_eq("wr rise", 16'(wr_now & ~wr_seen), (cyc == load_due) ? 16'(IB_NUM'('1)) : '0);
			for (int i = 0; i < IB_NUM; i++) begin
				if (wr_seen[i])  // drops only the cycle after an ack past the minimum
					check_eq("wr hold", 16'(wr_now[i]),
						16'(!(ack_seen[i] && wr_len[i] >= `LDPC_LOAD_MIN_CYC)));
				if (wr_now[i] && !wr_seen[i]) begin
					seed         = xorshift32(seed);
					ack_delay[i] = cur_ack + int'(seed & 32'd3);  // jitter 0..3
				end
				wr_len[i] = wr_now[i] ? wr_len[i] + 1 : 0;
			end
			if (pos_o.layer_finish) finishes++;
			if (layer_open && f == OFF_FIN) begin
				if (exp_layer[LAYERS-1]) begin
					exp_iter = exp_iter << 1;
					load_due = cyc + 1;  // pipe loads
				end else begin
					fetch_due = cyc + 1;
				end
				exp_layer  = {exp_layer[LAYERS-2:0], exp_layer[LAYERS-1]};
				layer_open = 1'b0;
			end
			if (termination_i) begin  // back through INIT_LOAD
				layer_open = 1'b0;
				fetch_due  = -1;
				load_due   = cyc + 2;
			end
			if ((|wr_seen) && !(|wr_now)) fetch_due = cyc + 1;  // all loads done
			if (fsm_en_i && !en_seen) load_due = cyc + 1;
			wr_seen  = wr_now;
			ack_seen = ack_drv;
			en_seen  = fsm_en_i;
		end
	end

	initial begin : watchdog
		int limit;
		limit = 8 + 100;  // reset plus margin
		for (int r = 0; r < ROWS; r++) limit += rows[r].layers * CYC_PER_LAYER;
		repeat (limit) @(posedge read_clk);
		$display("timeout: run did not finish within %0d cycles", limit);
		$display("TEST FAIL");
		$finish;
	end

	initial begin : stimulus
		int err0;
		int fin0;
		rstn          = 1'b0;
		fsm_en_i      = 1'b0;
		termination_i = 1'b0;
		repeat (8) @(posedge read_clk);
		rstn <= 1'b1;
		@(negedge read_clk);
		err0 = errors;
		check_eq("v2c after reset", 16'(v2c_o), '0);
		check_eq("ch after reset", 16'(ch_o), '0);
		check_eq("wr after reset", 16'({dnu_wr_o, vnu_wr_o}), '0);
		check_eq("busy after reset", 16'(decode_busy_o), '0);
		check_eq("position after reset", 16'({pos_o.layer, pos_o.iter}), 16'({3'b001, 8'h01}));
		$display("test 0: reset state, %0d errors", errors - err0);
		@(posedge read_clk);
		fsm_en_i <= 1'b1;
		for (int r = 0; r < ROWS; r++) begin
			err0    = errors;
			fin0    = finishes;
			cur_ack = rows[r].ack_dly;
			for (int l = 0; l < rows[r].layers; l++) begin
				wait_fetch();
				if (l == rows[r].term_layer) begin
					repeat (TERM_OFS) @(posedge read_clk);
					termination_i <= 1'b1;
					@(posedge read_clk);
					termination_i <= 1'b0;
					wait_load();  // init loads again
				end else begin
					wait_finish();
				end
			end
			@(posedge read_clk);  // let the monitor count the last pulse
			check_eq("layer_finish count", 16'(finishes - fin0), 16'(rows[r].exp_finish));
			$display("test %0d: %0d layers, ack delay %0d, termination in layer %0d, %0d errors",
				r + 1, rows[r].layers, rows[r].ack_dly, rows[r].term_layer, errors - err0);
		end
		$display("tests %0d, checks %0d, errors %0d", ROWS + 1, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
